/* flist.f */
+incdir+common
common/mips_pkg.sv
src/mips_alu.sv
src/mips_reg_file.sv
cpu/mips_control.sv
cpu/mips_datapath.sv
cpu/mips_cpu.sv
bench/tb_clock.sv
bench/tb_mips_cpu.sv

/* run.sh */
#!/bin/sh
# build and run from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_mips_cpu \
	-f flist.f -o tb_mips_cpu_sim &&
./obj_dir/tb_mips_cpu_sim | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

/* bench/mips_patterns.txt */
# P word_addr word | D word_addr word | R wen waddr wdata pc | M word_addr word
# all fields hex, addresses are word indexes into the memory
P 00 24010005
P 01 2402fffd
P 02 00221821
P 03 00222023
P 04 00222824
P 05 00223025
P 06 00223826
P 07 00224027
P 08 0041482a
P 09 0041502b
P 0a 304bf0f0
P 0b 340c8001
P 0c 3c0d1234
P 0d 24200007
P 0e 00017021
P 0f ac0d0200
P 10 8c0f0200
P 11 8c100204
P 12 ac100208
P 13 102e0001
P 14 24110bad
P 15 14220001
P 16 24110bad
P 17 10220001
P 18 142e0001
P 19 24120077
P 1a 0800001c
P 1b 24110bad
P 1c ac12020c
P 1d 0800001d
D 81 cafef00d
R 1 01 00000005 00000000
R 1 02 fffffffd 00000004
R 1 03 00000002 00000008
R 1 04 00000008 0000000c
R 1 05 00000005 00000010
R 1 06 fffffffd 00000014
R 1 07 fffffff8 00000018
R 1 08 00000002 0000001c
R 1 09 00000001 00000020
R 1 0a 00000000 00000024
R 1 0b 0000f0f0 00000028
R 1 0c 00008001 0000002c
R 1 0d 12340000 00000030
R 1 00 0000000c 00000034
R 1 0e 00000005 00000038
R 0 00 00000000 0000003c
R 1 0f 12340000 00000040
R 1 10 cafef00d 00000044
R 0 00 00000000 00000048
R 0 00 00000000 0000004c
R 0 00 00000000 00000054
R 0 00 00000000 0000005c
R 0 00 00000000 00000060
R 1 12 00000077 00000064
R 0 00 00000000 00000068
R 0 00 00000000 00000070
R 0 00 00000000 00000074
M 80 12340000
M 81 cafef00d
M 82 cafef00d
M 83 00000077

/* bench/tb_mips_cpu.sv */
`default_nettype none

`include "mips_settings.svh"

module tb_mips_cpu;

	timeunit 1ns;
	timeprecision 1ps;

	logic                        clk;
	logic                        rst;
	logic [`MIPS_XLEN-1:0]       pc;
	logic                        inst_req_valid;
	logic                        inst_req_ready;
	logic [`MIPS_XLEN-1:0]       instruction;
	logic                        inst_valid;
	logic                        inst_ready;
	logic [`MIPS_XLEN-1:0]       address;
	logic                        mem_read;
	logic                        mem_write;
	logic [`MIPS_XLEN-1:0]       write_data;
	logic [3:0]                  write_strb;
	logic                        mem_req_ready;
	logic [`MIPS_XLEN-1:0]       read_data;
	logic                        read_data_valid;
	logic                        read_data_ready;
	logic                        retire_valid;
	logic                        retire_wen;
	logic [`MIPS_REG_ADDR_W-1:0] retire_waddr;
	logic [`MIPS_XLEN-1:0]       retire_wdata;
	logic [`MIPS_XLEN-1:0]       retire_pc;

	// shared program and data memory of 1024 words
	logic [`MIPS_XLEN-1:0]       mem [1024];

	// expected retirement records and final memory words
	logic                        exp_wen [$];
	logic [`MIPS_REG_ADDR_W-1:0] exp_waddr [$];
	logic [`MIPS_XLEN-1:0]       exp_wdata [$];
	logic [`MIPS_XLEN-1:0]       exp_pc [$];
	logic [9:0]                  exp_mem_idx [$];
	logic [`MIPS_XLEN-1:0]       exp_mem_word [$];

	int                          n_prog;
	int                          rec_idx;
	int                          mismatches;
	int                          other_errors;
	logic                        loaded;
	logic                        done;
	logic                        first_fetch;
	logic [31:0]                 lfsr;

	// memory model state
	logic                        fetch_pend;
	logic [`MIPS_XLEN-1:0]       fetch_addr;
	logic                        load_pend;
	logic [`MIPS_XLEN-1:0]       load_addr;

	// handshakes and trace as seen just before the next rising edge
	logic                        s_inst_req;
	logic                        s_inst_resp;
	logic                        s_rd_req;
	logic                        s_rd_resp;
	logic                        s_wr;
	logic [`MIPS_XLEN-1:0]       s_pc;
	logic [`MIPS_XLEN-1:0]       s_addr;
	logic [`MIPS_XLEN-1:0]       s_wdata;
	logic [3:0]                  s_strb;
	logic                        s_ret;
	logic                        s_ret_wen;
	logic [`MIPS_REG_ADDR_W-1:0] s_ret_waddr;
	logic [`MIPS_XLEN-1:0]       s_ret_wdata;
	logic [`MIPS_XLEN-1:0]       s_ret_pc;

	tb_clock i_tb_clock (
		.clk (clk)
	);

	mips_cpu i_mips_cpu (
		.clk             (clk),
		.rst             (rst),
		.pc              (pc),
		.inst_req_valid  (inst_req_valid),
		.inst_req_ready  (inst_req_ready),
		.instruction     (instruction),
		.inst_valid      (inst_valid),
		.inst_ready      (inst_ready),
		.address         (address),
		.mem_read        (mem_read),
		.mem_write       (mem_write),
		.write_data      (write_data),
		.write_strb      (write_strb),
		.mem_req_ready   (mem_req_ready),
		.read_data       (read_data),
		.read_data_valid (read_data_valid),
		.read_data_ready (read_data_ready),
		.retire_valid    (retire_valid),
		.retire_wen      (retire_wen),
		.retire_waddr    (retire_waddr),
		.retire_wdata    (retire_wdata),
		.retire_pc       (retire_pc)
	);

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	task automatic take_bit(output logic b);
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		b = fb;
	endtask

	// one retirement record against the next expected one
	task automatic check_retire(
		input logic                        wen,
		input logic [`MIPS_REG_ADDR_W-1:0] waddr,
		input logic [`MIPS_XLEN-1:0]       wdata,
		input logic [`MIPS_XLEN-1:0]       rpc
	);
		logic bad;
		bad = (wen !== exp_wen[rec_idx]) || (rpc !== exp_pc[rec_idx]);
		// register target and value only count for writers
		if (exp_wen[rec_idx] && ((waddr !== exp_waddr[rec_idx]) ||
				(wdata !== exp_wdata[rec_idx])))
			bad = 1'b1;
		if (bad) begin
			mismatches++;
			$display("Mismatch at %0t: rec %0d got %0b r%0d=%h pc %h, exp %0b r%0d=%h pc %h",
				$time, rec_idx, wen, waddr, wdata, rpc, exp_wen[rec_idx],
				exp_waddr[rec_idx], exp_wdata[rec_idx], exp_pc[rec_idx]);
		end
	endtask

	task automatic check_word(
		input logic [9:0]            idx,
		input logic [`MIPS_XLEN-1:0] got,
		input logic [`MIPS_XLEN-1:0] exp
	);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: memory word at %h is %h, expected %h",
				$time, {idx, 2'b00}, got, exp);
		end
	endtask

	// every store writes all four bytes
	task automatic check_strb(input logic [3:0] got);
		if (got !== 4'b1111) begin
			mismatches++;
			$display("Mismatch at %0t: write strobe %b, expected 1111", $time, got);
		end
	endtask

	// reads tagged lines P, D, R and M and skips all others
	task automatic load_patterns();
		int    fd;
		int    code;
		string line;
		string rest;
		byte   tag;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		fd = $fopen("bench/mips_patterns.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("cannot open bench/mips_patterns.txt");
			return;
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (line.len() < 2)
				continue;
			tag = line.getc(0);
			rest = line.substr(1, line.len() - 1);
			code = $sscanf(rest, "%h %h %h %h", f0, f1, f2, f3);
			case (tag)
				"P": begin
					mem[f0[9:0]] = f1;
					n_prog++;
				end
				"D": mem[f0[9:0]] = f1;
				"R": begin
					exp_wen.push_back(f0[0]);
					exp_waddr.push_back(f1[`MIPS_REG_ADDR_W-1:0]);
					exp_wdata.push_back(f2);
					exp_pc.push_back(f3);
				end
				"M": begin
					exp_mem_idx.push_back(f0[9:0]);
					exp_mem_word.push_back(f1);
				end
				default: ;
			endcase
		end
		$fclose(fd);
	endtask

	// memory model and retirement monitor run on the falling edge
	initial begin
		logic b;
		forever begin
			@(negedge clk);
			if (!rst && loaded) begin
				if (s_inst_req) begin
					fetch_pend = 1'b1;
					fetch_addr = s_pc;
					// the first fetch has to use the reset pc
					if (first_fetch && (s_pc !== `MIPS_RESET_PC)) begin
						mismatches++;
						$display("Mismatch at %0t: first fetch from %h, expected %h",
							$time, s_pc, `MIPS_RESET_PC);
					end
					first_fetch = 1'b0;
				end
				if (s_inst_resp)
					fetch_pend = 1'b0;
				if (s_rd_req) begin
					load_pend = 1'b1;
					load_addr = s_addr;
				end
				if (s_rd_resp)
					load_pend = 1'b0;
				if (s_wr) begin
					check_strb(s_strb);
					mem[s_addr[11:2]] = s_wdata;
				end
				if (s_ret && !done) begin
					if (rec_idx >= exp_wen.size()) begin
						other_errors++;
						$display("extra retirement at %0t from pc %h", $time, s_ret_pc);
					end else begin
						check_retire(s_ret_wen, s_ret_waddr, s_ret_wdata, s_ret_pc);
						rec_idx++;
						if (rec_idx == exp_wen.size())
							done = 1'b1;
					end
				end
			end
			// random stalls on every channel
			take_bit(b);
			inst_req_ready = b;
			take_bit(b);
			mem_req_ready = b;
			take_bit(b);
			inst_valid = fetch_pend && b;
			instruction = fetch_pend ? mem[fetch_addr[11:2]] : '0;
			take_bit(b);
			read_data_valid = load_pend && b;
			read_data = load_pend ? mem[load_addr[11:2]] : '0;
			#1;
			s_inst_req  = inst_req_valid && inst_req_ready;
			s_inst_resp = inst_valid && inst_ready;
			s_rd_req    = mem_read && mem_req_ready;
			s_rd_resp   = read_data_valid && read_data_ready;
			s_wr        = mem_write && mem_req_ready;
			s_pc        = pc;
			s_addr      = address;
			s_wdata     = write_data;
			s_strb      = write_strb;
			s_ret       = retire_valid;
			s_ret_wen   = retire_wen;
			s_ret_waddr = retire_waddr;
			s_ret_wdata = retire_wdata;
			s_ret_pc    = retire_pc;
		end
	end

	// 40 cycles per program word times four for stalls
	initial begin
		wait (loaded);
		#(n_prog * 40 * 4 * 8);
		$display("timeout: %0d of %0d retirements seen", rec_idx, exp_wen.size());
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		rst = 1'b1;
		inst_req_ready = 1'b0;
		instruction = '0;
		inst_valid = 1'b0;
		mem_req_ready = 1'b0;
		read_data = '0;
		read_data_valid = 1'b0;
		lfsr = 32'hf410abec;
		n_prog = 0;
		rec_idx = 0;
		mismatches = 0;
		other_errors = 0;
		done = 1'b0;
		first_fetch = 1'b1;
		fetch_pend = 1'b0;
		fetch_addr = '0;
		load_pend = 1'b0;
		load_addr = '0;
		{s_inst_req, s_inst_resp, s_rd_req, s_rd_resp, s_wr, s_ret} = '0;
		// background fill from the full word index
		for (int i = 0; i < 1024; i++)
			mem[i] = {i[15:0] ^ 16'h5a5a, i[15:0]};
		load_patterns();
		loaded = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		// outputs while still in reset
		if (inst_req_valid !== 1'b0 || mem_read !== 1'b0 || mem_write !== 1'b0) begin
			mismatches++;
			$display("Mismatch at %0t: strobes high in reset (%b %b %b)",
				$time, inst_req_valid, mem_read, mem_write);
		end
		if (pc !== `MIPS_RESET_PC) begin
			mismatches++;
			$display("Mismatch at %0t: pc %h in reset", $time, pc);
		end
		rst = 1'b0;
		wait (done);
		@(negedge clk);
		for (int i = 0; i < exp_mem_idx.size(); i++)
			check_word(exp_mem_idx[i], mem[exp_mem_idx[i]], exp_mem_word[i]);
		$display("errors: %0d mismatches, %0d other", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`default_nettype none

module tb_clock (
	output logic clk
);

	timeunit 1ns;
	timeprecision 1ps;

	// 8 ns period, low at time zero
	initial clk = 1'b0;
	always #4 clk = ~clk;

endmodule

`default_nettype wire

/* cpu/mips_cpu.sv */
`default_nettype none

`include "mips_settings.svh"

module mips_cpu (
	input  wire                         clk,
	input  wire                         rst,

	// instruction request and response
	output logic [`MIPS_XLEN-1:0]       pc,
	output logic                        inst_req_valid,
	input  wire                         inst_req_ready,
	input  wire  [`MIPS_XLEN-1:0]       instruction,
	input  wire                         inst_valid,
	output logic                        inst_ready,

	// data request and response
	output logic [`MIPS_XLEN-1:0]       address,
	output logic                        mem_read,
	output logic                        mem_write,
	output logic [`MIPS_XLEN-1:0]       write_data,
	output logic [3:0]                  write_strb,
	input  wire                         mem_req_ready,
	input  wire  [`MIPS_XLEN-1:0]       read_data,
	input  wire                         read_data_valid,
	output logic                        read_data_ready,

	// retirement trace
	output logic                        retire_valid,
	output logic                        retire_wen,
	output logic [`MIPS_REG_ADDR_W-1:0] retire_waddr,
	output logic [`MIPS_XLEN-1:0]       retire_wdata,
	output logic [`MIPS_XLEN-1:0]       retire_pc
);

	// decode feedback from the datapath
	mips_pkg::opcode_e opcode;
	mips_pkg::funct_e  funct;
	logic              alu_zero;

	// control lines into the datapath
	logic              ir_load;
	logic              rd_load;
	logic              pc_inc;
	logic              pc_take;
	mips_pkg::alu_op_e alu_op;
	logic              alu_src_imm;
	logic              imm_zero_ext;
	logic              use_lui;
	logic              branch_sel;
	logic              jump;
	logic              wb_sel_mem;
	logic              wb_dst_rt;
	logic              rf_wen;

	// only full word stores exist
	assign write_strb = 4'b1111;

	mips_control i_mips_control (
		.clk             (clk),
		.rst             (rst),
		.opcode          (opcode),
		.funct           (funct),
		.alu_zero        (alu_zero),
		.inst_req_ready  (inst_req_ready),
		.inst_valid      (inst_valid),
		.mem_req_ready   (mem_req_ready),
		.read_data_valid (read_data_valid),
		.state           (),
		.inst_req_valid  (inst_req_valid),
		.inst_ready      (inst_ready),
		.read_data_ready (read_data_ready),
		.mem_read        (mem_read),
		.mem_write       (mem_write),
		.ir_load         (ir_load),
		.rd_load         (rd_load),
		.pc_inc          (pc_inc),
		.pc_take         (pc_take),
		.alu_op          (alu_op),
		.alu_src_imm     (alu_src_imm),
		.imm_zero_ext    (imm_zero_ext),
		.use_lui         (use_lui),
		.branch_sel      (branch_sel),
		.jump            (jump),
		.wb_sel_mem      (wb_sel_mem),
		.wb_dst_rt       (wb_dst_rt),
		.rf_wen          (rf_wen),
		.retire_valid    (retire_valid)
	);

	mips_datapath i_mips_datapath (
		.clk          (clk),
		.rst          (rst),
		.instruction  (instruction),
		.read_data    (read_data),
		.ir_load      (ir_load),
		.rd_load      (rd_load),
		.pc_inc       (pc_inc),
		.pc_take      (pc_take),
		.alu_op       (alu_op),
		.alu_src_imm  (alu_src_imm),
		.imm_zero_ext (imm_zero_ext),
		.use_lui      (use_lui),
		.branch_sel   (branch_sel),
		.jump         (jump),
		.wb_sel_mem   (wb_sel_mem),
		.wb_dst_rt    (wb_dst_rt),
		.rf_wen       (rf_wen),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.opcode       (opcode),
		.funct        (funct),
		.alu_zero     (alu_zero),
		.pc           (pc),
		.address      (address),
		.write_data   (write_data),
		.retire_wen   (retire_wen),
		.retire_waddr (retire_waddr),
		.retire_wdata (retire_wdata),
		.retire_pc    (retire_pc)
	);

endmodule

`default_nettype wire

/* cpu/mips_datapath.sv */
`default_nettype none

`include "mips_settings.svh"

module mips_datapath (
	input  wire                         clk,
	input  wire                         rst,
	input  wire  [`MIPS_XLEN-1:0]       instruction,
	input  wire  [`MIPS_XLEN-1:0]       read_data,
	input  wire                         ir_load,
	input  wire                         rd_load,
	input  wire                         pc_inc,
	input  wire                         pc_take,
	input  wire mips_pkg::alu_op_e      alu_op,
	input  wire                         alu_src_imm,
	input  wire                         imm_zero_ext,
	input  wire                         use_lui,
	input  wire                         branch_sel,
	input  wire                         jump,
	input  wire                         wb_sel_mem,
	input  wire                         wb_dst_rt,
	input  wire                         rf_wen,
	input  wire                         mem_read,
	input  wire                         mem_write,
	output mips_pkg::opcode_e           opcode,
	output mips_pkg::funct_e            funct,
	output logic                        alu_zero,
	output logic [`MIPS_XLEN-1:0]       pc,
	output logic [`MIPS_XLEN-1:0]       address,
	output logic [`MIPS_XLEN-1:0]       write_data,
	output logic                        retire_wen,
	output logic [`MIPS_REG_ADDR_W-1:0] retire_waddr,
	output logic [`MIPS_XLEN-1:0]       retire_wdata,
	output logic [`MIPS_XLEN-1:0]       retire_pc
);

	logic [`MIPS_XLEN-1:0]       ir;
	logic [`MIPS_XLEN-1:0]       rd_reg;
	logic [`MIPS_XLEN-1:0]       pc_retire;
	logic [`MIPS_REG_ADDR_W-1:0] rs;
	logic [`MIPS_REG_ADDR_W-1:0] rt;
	logic [`MIPS_REG_ADDR_W-1:0] rd;
	logic [15:0]                 imm;
	logic [25:0]                 index;
	logic [`MIPS_XLEN-1:0]       imm_ext;
	logic [`MIPS_XLEN-1:0]       br_target;
	logic [`MIPS_XLEN-1:0]       j_target;
	logic [`MIPS_XLEN-1:0]       rdata1;
	logic [`MIPS_XLEN-1:0]       rdata2;
	logic [`MIPS_XLEN-1:0]       alu_a;
	logic [`MIPS_XLEN-1:0]       alu_b;
	logic [`MIPS_XLEN-1:0]       alu_result;
	logic [`MIPS_REG_ADDR_W-1:0] waddr;
	logic [`MIPS_XLEN-1:0]       wdata;

	// instruction word, held until the next fetch
	always_ff @(posedge clk) begin
		if (ir_load)
			ir <= instruction;
	end

	// loaded word, captured on the read response
	always_ff @(posedge clk) begin
		if (rd_load)
			rd_reg <= read_data;
	end

	// pc of the instruction in flight, taken before the increment
	always_ff @(posedge clk) begin
		if (pc_inc)
			pc_retire <= pc;
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= `MIPS_RESET_PC;
		else if (pc_inc)
			pc <= alu_result;
		else if (pc_take && jump)
			pc <= j_target;
		else if (pc_take && branch_sel)
			pc <= br_target;
	end

	// instruction fields
	assign opcode = mips_pkg::opcode_e'(ir[31:26]);
	assign funct  = mips_pkg::funct_e'(ir[5:0]);
	assign rs     = ir[25:21];
	assign rt     = ir[20:16];
	assign rd     = ir[15:11];
	assign imm    = ir[15:0];
	assign index  = ir[25:0];

	assign imm_ext = imm_zero_ext ? {{(`MIPS_XLEN-16){1'b0}}, imm} :
		{{(`MIPS_XLEN-16){imm[15]}}, imm};

	// pc already holds pc+4 by EX
	assign br_target = pc + {{(`MIPS_XLEN-18){imm[15]}}, imm, 2'b00};
	assign j_target  = {pc[`MIPS_XLEN-1 -: 4], index, 2'b00};

	// pc+4 in IW, register or immediate operands otherwise
	assign alu_a = pc_inc ? pc : rdata1;
	assign alu_b = pc_inc ? `MIPS_INST_BYTES : (alu_src_imm ? imm_ext : rdata2);

	mips_alu i_mips_alu (
		.a      (alu_a),
		.b      (alu_b),
		.op     (alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// write-back select
	assign waddr = wb_dst_rt ? rt : rd;
	assign wdata = wb_sel_mem ? rd_reg : (use_lui ? {imm, 16'h0000} : alu_result);

	mips_reg_file i_mips_reg_file (
		.clk    (clk),
		.raddr1 (rs),
		.raddr2 (rt),
		.waddr  (waddr),
		.wdata  (wdata),
		.wen    (rf_wen),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	// base plus offset stays on the alu through LD and ST
	assign address    = alu_result;
	assign write_data = rdata2;

	assign retire_wen   = rf_wen;
	assign retire_waddr = waddr;
	assign retire_wdata = wdata;
	assign retire_pc    = pc_retire;

	a_word_aligned: assert property (@(posedge clk) disable iff (rst)
		(mem_read || mem_write) |-> (address[1:0] == 2'b00));

endmodule

`default_nettype wire

/* cpu/mips_control.sv */
`default_nettype none

module mips_control (
	input  wire                      clk,
	input  wire                      rst,
	input  wire mips_pkg::opcode_e   opcode,
	input  wire mips_pkg::funct_e    funct,
	input  wire                      alu_zero,
	input  wire                      inst_req_ready,
	input  wire                      inst_valid,
	input  wire                      mem_req_ready,
	input  wire                      read_data_valid,
	output mips_pkg::cpu_state_e     state,
	output logic                     inst_req_valid,
	output logic                     inst_ready,
	output logic                     read_data_ready,
	output logic                     mem_read,
	output logic                     mem_write,
	output logic                     ir_load,
	output logic                     rd_load,
	output logic                     pc_inc,
	output logic                     pc_take,
	output mips_pkg::alu_op_e        alu_op,
	output logic                     alu_src_imm,
	output logic                     imm_zero_ext,
	output logic                     use_lui,
	output logic                     branch_sel,
	output logic                     jump,
	output logic                     wb_sel_mem,
	output logic                     wb_dst_rt,
	output logic                     rf_wen,
	output logic                     retire_valid
);

	mips_pkg::cpu_state_e state_next;
	mips_pkg::alu_op_e    r_alu_op;
	logic                 is_r_alu;
	logic                 is_i_alu;
	logic                 is_nop;
	logic                 br_taken;

	// r-type funct to alu op
	// unknown functs are not executed
	always_comb begin
		is_r_alu = opcode == mips_pkg::OP_SPECIAL;
		case (funct)
			mips_pkg::FN_ADDU: r_alu_op = mips_pkg::ALU_ADD;
			mips_pkg::FN_SUBU: r_alu_op = mips_pkg::ALU_SUB;
			mips_pkg::FN_AND:  r_alu_op = mips_pkg::ALU_AND;
			mips_pkg::FN_OR:   r_alu_op = mips_pkg::ALU_OR;
			mips_pkg::FN_XOR:  r_alu_op = mips_pkg::ALU_XOR;
			mips_pkg::FN_NOR:  r_alu_op = mips_pkg::ALU_NOR;
			mips_pkg::FN_SLT:  r_alu_op = mips_pkg::ALU_SLT;
			mips_pkg::FN_SLTU: r_alu_op = mips_pkg::ALU_SLTU;
			default: begin
				r_alu_op = mips_pkg::ALU_ADD;
				is_r_alu = 1'b0;
			end
		endcase
	end

	// i-type ops that write back including lui
	assign is_i_alu = (opcode == mips_pkg::OP_ADDIU) || (opcode == mips_pkg::OP_ANDI) ||
		(opcode == mips_pkg::OP_ORI) || (opcode == mips_pkg::OP_LUI);
	// the all-zero word has opcode and funct zero
	assign is_nop = (opcode == mips_pkg::OP_SPECIAL) && (funct == 6'h00);

	// instruction class decode independent of state
	assign alu_src_imm  = (opcode == mips_pkg::OP_ADDIU) || (opcode == mips_pkg::OP_ANDI) ||
		(opcode == mips_pkg::OP_ORI) || (opcode == mips_pkg::OP_LW) ||
		(opcode == mips_pkg::OP_SW);
	assign imm_zero_ext = (opcode == mips_pkg::OP_ANDI) || (opcode == mips_pkg::OP_ORI);
	assign use_lui      = opcode == mips_pkg::OP_LUI;
	assign branch_sel   = (opcode == mips_pkg::OP_BEQ) || (opcode == mips_pkg::OP_BNE);
	assign jump         = opcode == mips_pkg::OP_J;
	assign wb_sel_mem   = opcode == mips_pkg::OP_LW;
	// every i-type writer targets rt
	assign wb_dst_rt    = opcode != mips_pkg::OP_SPECIAL;

	// alu op by instruction with pc+4 forced in IW
	always_comb begin
		case (opcode)
			mips_pkg::OP_SPECIAL: alu_op = r_alu_op;
			mips_pkg::OP_ANDI:    alu_op = mips_pkg::ALU_AND;
			mips_pkg::OP_ORI:     alu_op = mips_pkg::ALU_OR;
			mips_pkg::OP_BEQ:     alu_op = mips_pkg::ALU_SUB;
			mips_pkg::OP_BNE:     alu_op = mips_pkg::ALU_SUB;
			default:              alu_op = mips_pkg::ALU_ADD;
		endcase
		if (state == mips_pkg::S_IW)
			alu_op = mips_pkg::ALU_ADD;
	end

	// rs-rt compare result from the alu
	assign br_taken = ((opcode == mips_pkg::OP_BEQ) && alu_zero) ||
		((opcode == mips_pkg::OP_BNE) && !alu_zero);

	always_ff @(posedge clk) begin
		if (rst)
			state <= mips_pkg::S_RST;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			mips_pkg::S_RST: state_next = mips_pkg::S_IF;
			mips_pkg::S_IF: begin
				if (inst_req_ready)
					state_next = mips_pkg::S_IW;
			end
			mips_pkg::S_IW: begin
				if (inst_valid)
					state_next = mips_pkg::S_ID;
			end
			// all-zero word skips execution
			mips_pkg::S_ID: state_next = is_nop ? mips_pkg::S_IF : mips_pkg::S_EX;
			mips_pkg::S_EX: begin
				if (is_r_alu || is_i_alu)
					state_next = mips_pkg::S_WB;
				else if (opcode == mips_pkg::OP_LW)
					state_next = mips_pkg::S_LD;
				else if (opcode == mips_pkg::OP_SW)
					state_next = mips_pkg::S_ST;
				else
					state_next = mips_pkg::S_IF;
			end
			mips_pkg::S_LD: begin
				if (mem_req_ready)
					state_next = mips_pkg::S_RDW;
			end
			mips_pkg::S_ST: begin
				if (mem_req_ready)
					state_next = mips_pkg::S_IF;
			end
			mips_pkg::S_RDW: begin
				if (read_data_valid)
					state_next = mips_pkg::S_WB;
			end
			mips_pkg::S_WB: state_next = mips_pkg::S_IF;
			default: state_next = mips_pkg::S_RST;
		endcase
	end

	// channel strobes
	assign inst_req_valid  = state == mips_pkg::S_IF;
	// responses are drained in reset too
	assign inst_ready      = (state == mips_pkg::S_RST) || (state == mips_pkg::S_IW);
	assign read_data_ready = (state == mips_pkg::S_RST) || (state == mips_pkg::S_RDW);
	assign mem_read        = state == mips_pkg::S_LD;
	assign mem_write       = state == mips_pkg::S_ST;

	// register loads on handshake
	assign ir_load = (state == mips_pkg::S_IW) && inst_valid;
	assign pc_inc  = ir_load;
	assign rd_load = (state == mips_pkg::S_RDW) && read_data_valid;
	// only taken branches and j redirect the pc
	assign pc_take = (state == mips_pkg::S_EX) && (jump || br_taken);
	// only WB is reached by writers
	assign rf_wen  = state == mips_pkg::S_WB;

	// one pulse per retired instruction
	assign retire_valid = rf_wen || ((state == mips_pkg::S_EX) && (branch_sel || jump)) ||
		(mem_write && mem_req_ready);

	// a data request belongs to the load or store held in the ir
	a_ld_op: assert property (@(posedge clk) disable iff (rst)
		mem_read |-> (opcode == mips_pkg::OP_LW));
	a_st_op: assert property (@(posedge clk) disable iff (rst)
		mem_write |-> (opcode == mips_pkg::OP_SW));
	a_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(state));

endmodule

`default_nettype wire

/* src/mips_reg_file.sv */
`default_nettype none

`include "mips_settings.svh"

module mips_reg_file (
	input  wire                         clk,
	input  wire  [`MIPS_REG_ADDR_W-1:0] raddr1,
	input  wire  [`MIPS_REG_ADDR_W-1:0] raddr2,
	input  wire  [`MIPS_REG_ADDR_W-1:0] waddr,
	input  wire  [`MIPS_XLEN-1:0]       wdata,
	input  wire                         wen,
	output logic [`MIPS_XLEN-1:0]       rdata1,
	output logic [`MIPS_XLEN-1:0]       rdata2
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

	// register zero is never written
	always_ff @(posedge clk) begin
		if (wen && (waddr != '0))
			regs[waddr] <= wdata;
	end

	// asynchronous reads, zero forced for register 0
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* src/mips_alu.sv */
`default_nettype none

`include "mips_settings.svh"

module mips_alu (
	input  wire  [`MIPS_XLEN-1:0] a,
	input  wire  [`MIPS_XLEN-1:0] b,
	input  wire mips_pkg::alu_op_e op,
	output logic [`MIPS_XLEN-1:0] result,
	output logic                  zero
);

	logic lt_signed;
	logic lt_unsigned;

	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			mips_pkg::ALU_ADD:  result = a + b;
			mips_pkg::ALU_SUB:  result = a - b;
			mips_pkg::ALU_AND:  result = a & b;
			mips_pkg::ALU_OR:   result = a | b;
			mips_pkg::ALU_XOR:  result = a ^ b;
			mips_pkg::ALU_NOR:  result = ~(a | b);
			// set-less-than gives 0 or 1
			mips_pkg::ALU_SLT:  result = {{(`MIPS_XLEN-1){1'b0}}, lt_signed};
			mips_pkg::ALU_SLTU: result = {{(`MIPS_XLEN-1){1'b0}}, lt_unsigned};
			default:            result = a + b;
		endcase
	end

	// equality for beq and bne after a subtract
	assign zero = result == '0;

endmodule

`default_nettype wire

/* common/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	// controller states, one-hot with reset as the all-zero code
	typedef enum logic [7:0] {
		S_RST = 8'b0000_0000,
		S_IF  = 8'b0000_0001,
		S_IW  = 8'b0000_0010,
		S_ID  = 8'b0000_0100,
		S_EX  = 8'b0000_1000,
		S_LD  = 8'b0001_0000,
		S_ST  = 8'b0010_0000,
		S_RDW = 8'b0100_0000,
		S_WB  = 8'b1000_0000
	} cpu_state_e;

	// primary opcodes, instruction bits 31:26
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	// r-type function codes, instruction bits 5:0
	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_e;

	// alu operation select
	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_AND  = 3'd2,
		ALU_OR   = 3'd3,
		ALU_XOR  = 3'd4,
		ALU_NOR  = 3'd5,
		ALU_SLT  = 3'd6,
		ALU_SLTU = 3'd7
	} alu_op_e;

endpackage

`default_nettype wire

/* common/mips_settings.svh */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// word width, used for data, addresses and the pc
`define MIPS_XLEN 32

// register index width and register count
`define MIPS_REG_ADDR_W 5
`define MIPS_NUM_REGS 32

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// byte step between sequential instructions
`define MIPS_INST_BYTES 32'd4

`endif
